// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = cop_tb
FILELIST = filelist.f
PASS_MSG = ** PASS **
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/cop_sva.sv ====
/*
 * Bus and completion assertions for the memory access block
 */
module cop_sva (
    input logic                  g_clk,
    input logic                  g_resetn,
    input logic                  valid,
    input cop_pkg::cop_id_t      id,
    input logic                  done,
    input logic                  addr_error,
    input cop_pkg::cop_mem_req_t req,
    input cop_pkg::cop_mem_rsp_t rsp
);

    // A misaligned access never reaches the bus
    no_cen_on_addr_error: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(req.cen && addr_error))
        else $error("request issued with addr_error");

    stall_holds_request: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $past(req.cen) && rsp.stall |-> req.cen && req == $past(req))
        else $error("request changed under stall");

    // Idle after completion unless a new instruction follows
    quiet_after_done: assert property (@(posedge g_clk) disable iff (!g_resetn)
        done |=> !req.cen || (valid && id != $past(id)))
        else $error("request after done without a new instruction");

endmodule

bind cop_mem cop_sva u_sva (
    .g_clk      (g_clk),
    .g_resetn   (g_resetn),
    .valid      (valid),
    .id         (id),
    .done       (done),
    .addr_error (addr_error),
    .req        (req),
    .rsp        (rsp)
);

// ==== bench/cop_tb.sv ====
/*
 * Testbench for the coprocessor load/store unit
 * Memory model with stall and error injection, directed tests
 */
module cop_tb;
    import cop_pkg::*;

    localparam int max_cycles = 6000;   // ~190 instr, 4 accesses, 3 stalls each, plus margin

    logic g_clk, g_resetn, instr_valid;
    cop_instr_u   instr;
    logic [31:0]  gpr_rs1;
    logic         instr_done, addr_error, bus_error, is_store;
    cop_mem_req_t mem_req, pend_req;
    cop_mem_rsp_t mem_rsp;
    logic [31:0]  mem [256];
    logic [31:0]  seed = 32'hc801;
    logic [31:0]  err_addr;
    logic [3:0]   last_ben;
    logic         pend, stall_en, err_en, saw_cen, got_aerr, got_berr, got_store;
    int           stall_left, accesses, writes, errors, checks, cycles;

    cop_top u_cop_top (.*);

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;
    end

    always @(posedge g_clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: no completion after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [31:0] fill(input int i);
        return 32'h3c5a96e1 ^ (i * 32'h01010101);   // Every byte tracks the index
    endfunction

    // Memory model, request seen at posedge, answered from the next negedge
    always @(posedge g_clk) begin
        pend_req <= mem_req;
        pend     <= g_resetn && mem_req.cen;
    end

    always @(negedge g_clk) begin
        logic [31:0] r;
        mem_rsp.stall = 1'b0;
        mem_rsp.error = 1'b0;
        if (pend) begin
            if (stall_left > 0) begin
                mem_rsp.stall = 1'b1;
                stall_left--;
            end else begin
                accesses++;
                if (err_en && pend_req.addr == err_addr) begin
                    mem_rsp.error = 1'b1;
                end else if (pend_req.wen) begin
                    writes++;
                    last_ben = pend_req.ben;
                    for (int b = 0; b < 4; b++) begin
                        if (pend_req.ben[b])
                            mem[pend_req.addr[9:2]][8*b +: 8] = pend_req.wdata[8*b +: 8];
                    end
                end else begin
                    mem_rsp.rdata = mem[pend_req.addr[9:2]];
                end
                r = lcg_next();
                stall_left = stall_en ? int'(r[17:16]) : 0;   // Stalls for the next access
            end
        end
    end

    function automatic cop_instr_u ls_instr(input cop_sclass_e sc, input logic [3:0] rd,
                                            input logic [3:0] rs2, input logic [1:0] part,
                                            input logic [11:0] imm);
        cop_instr_u w;
        w = '0;
        w.ls.cls    = iclass_loadstore;
        w.ls.sclass = sc;
        w.ls.rd     = rd;
        w.ls.rs2    = rs2;
        w.ls.wb_h   = part[1];
        w.ls.wb_b   = part[0];
        w.ls.imm    = imm;
        return w;
    endfunction

    function automatic cop_instr_u sg_instr(input cop_sclass_e sc, input logic [3:0] rd,
                                            input logic [3:0] rs2, input logic [3:0] rs3);
        cop_instr_u w;
        w = '0;
        w.sg.cls    = iclass_loadstore;
        w.sg.sclass = sc;
        w.sg.rd     = rd;
        w.sg.rs2    = rs2;
        w.sg.rs3    = rs3;
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // One instruction, held until done
    task automatic issue(input cop_instr_u iw, input logic [31:0] rs1);
        @(negedge g_clk);
        instr       = iw;
        gpr_rs1     = rs1;
        instr_valid = 1'b1;
        accesses    = 0;
        writes      = 0;
        saw_cen     = 1'b0;
        do begin
            @(posedge g_clk);
            if (mem_req.cen) saw_cen = 1'b1;
        end while (!instr_done);
        got_aerr  = addr_error;
        got_berr  = bus_error;
        got_store = is_store;
        @(negedge g_clk);
        instr_valid = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] idx, output logic [31:0] val);
        issue(ls_instr(st_w, 4'd0, idx, 2'd0, 12'h000), 32'h3fc);   // Scratch word 255
        val = mem[255];
    endtask

    task automatic report(input string name, input int e0);
        $display("%-24s %s", name, errors == e0 ? "ok" : "failed");
    endtask

    task automatic test_word_round_trip(input string sfx);
        int e0 = errors;
        logic [31:0] src;
        src     = lcg_next();   // New word for each run
        mem[16] = src;
        mem[32] = fill(32);
        issue(ls_instr(ld_w, 4'd1, 4'd0, 2'd0, 12'h010), 32'h30);
        check("is_store", got_store, 0);
        issue(ls_instr(st_w, 4'd0, 4'd1, 2'd0, 12'hff0), 32'h90);   // 0x90 - 16
        check("is_store", got_store, 1);
        check("mem[0x80]", mem[32], src);
        check("mem_req.ben", {28'h0, last_ben}, 32'hf);
        check("writes", writes, 1);
        report({"word round trip", sfx}, e0);
    endtask

    task automatic test_narrow_loads(input string sfx);
        int e0 = errors;
        logic [31:0] v, exp;
        mem[64] = 32'h11223344;
        mem[65] = 32'h8899aabb;
        for (int p = 0; p < 4; p++) begin
            for (int o = 0; o < 4; o++) begin
                issue(ls_instr(ld_w, 4'd2, 4'd0, 2'd0, 12'h000), 32'h104);
                issue(ls_instr(lb_cr, 4'd2, 4'd0, p[1:0], o[11:0]), 32'h100);
                read_reg(4'd2, v);
                exp = (p == 0) ? 32'h0 : 32'h8899aabb;   // Part 0 clears bytes 3..1
                exp[8*p +: 8] = mem[64][8*o +: 8];
                check($sformatf("cpr2 lb part%0d off%0d", p, o), v, exp);
            end
        end
        for (int h = 0; h < 2; h++) begin
            for (int o = 0; o < 4; o += 2) begin
                issue(ls_instr(ld_w, 4'd2, 4'd0, 2'd0, 12'h000), 32'h104);
                issue(ls_instr(lh_cr, 4'd2, 4'd0, {h[0], 1'b0}, 12'h000), 32'h100 + o);
                read_reg(4'd2, v);
                exp = (h == 0) ? 32'h0 : 32'h8899aabb;
                exp[16*h +: 16] = mem[64][8*o +: 16];
                check($sformatf("cpr2 lh half%0d off%0d", h, o), v, exp);
            end
        end
        report({"byte/half loads", sfx}, e0);
    endtask

    task automatic test_narrow_stores(input string sfx);
        int e0 = errors;
        logic [31:0] exp;
        mem[66] = 32'hd4c3b2a1;
        issue(ls_instr(ld_w, 4'd3, 4'd0, 2'd0, 12'h000), 32'h108);
        for (int p = 0; p < 4; p++) begin
            for (int o = 0; o < 4; o++) begin
                mem[72] = fill(72);
                issue(ls_instr(st_b, 4'd0, 4'd3, p[1:0], o[11:0]), 32'h120);
                exp = fill(72);
                exp[8*o +: 8] = mem[66][8*p +: 8];
                check($sformatf("mem sb part%0d off%0d", p, o), mem[72], exp);
                check("mem_req.ben", {28'h0, last_ben}, 32'h1 << o);
            end
        end
        for (int h = 0; h < 2; h++) begin
            for (int o = 0; o < 4; o += 2) begin
                mem[72] = fill(72);
                issue(ls_instr(st_h, 4'd0, 4'd3, {h[0], 1'b0}, o[11:0]), 32'h120);
                exp = fill(72);
                exp[8*o +: 16] = mem[66][16*h +: 16];
                check($sformatf("mem sh half%0d off%0d", h, o), mem[72], exp);
                check("mem_req.ben", {28'h0, last_ben}, (o == 0) ? 32'h3 : 32'hc);
            end
        end
        report({"byte/half stores", sfx}, e0);
    endtask

    // Scatter rs3 parts to rs1 + rs2 offsets, gather back, store and compare
    task automatic test_scatter_gather(input string sfx);
        int e0 = errors;
        logic [31:0] offs, data, a, exp, v;
        for (int hw = 0; hw < 2; hw++) begin
            offs = hw ? 32'h000e0004 : 32'h0f0a0500;
            data = hw ? 32'h9abcdef0 : 32'h5e6f7a8b;
            mem[67] = offs;
            mem[68] = data;
            issue(ls_instr(ld_w, 4'd4, 4'd0, 2'd0, 12'h000), 32'h10c);
            issue(ls_instr(ld_w, 4'd5, 4'd0, 2'd0, 12'h000), 32'h110);
            for (int k = 0; k < 4; k++) begin
                mem[8'hc0 + k] = fill(8'hc0 + k);
                mem[8'hd0 + k] = fill(8'hd0 + k);
            end
            issue(sg_instr(hw ? scatter_h : scatter_b, 4'd0, 4'd4, 4'd5), hw ? 32'h340 : 32'h300);
            check("is_store", got_store, 1);
            check("scatter accesses", accesses, hw ? 2 : 4);
            check("scatter writes", writes, hw ? 2 : 4);
            for (int k = 0; k < (hw ? 2 : 4); k++) begin
                a = hw ? 32'h340 + offs[16*k +: 16] : 32'h300 + offs[8*k +: 8];
                exp = fill(int'(a[9:2]));
                if (hw) exp[8*a[1:0] +: 16] = data[16*k +: 16];
                else    exp[8*a[1:0] +: 8] = data[8*k +: 8];
                check($sformatf("mem scatter step%0d", k), mem[a[9:2]], exp);
            end
            issue(sg_instr(hw ? gather_h : gather_b, 4'd6, 4'd4, 4'd0), hw ? 32'h340 : 32'h300);
            check("is_store", got_store, 0);
            check("gather accesses", accesses, hw ? 2 : 4);
            read_reg(4'd6, v);
            check("cpr6 gather", v, data);
        end
        report({"scatter/gather", sfx}, e0);
    endtask

    task automatic test_errors();
        int e0 = errors;
        logic [31:0] v, m;
        mem[71] = 32'h77771234;
        mem[73] = 32'h00000003;
        issue(ls_instr(ld_w, 4'd7, 4'd0, 2'd0, 12'h000), 32'h11c);
        issue(ls_instr(ld_w, 4'd8, 4'd0, 2'd0, 12'h000), 32'h124);
        issue(ls_instr(ld_w, 4'd7, 4'd0, 2'd0, 12'h001), 32'h40);
        expect_true(got_aerr && !saw_cen, "misaligned word load not rejected cleanly");
        m = mem[32];
        issue(ls_instr(st_w, 4'd0, 4'd7, 2'd0, 12'h000), 32'h82);
        expect_true(got_aerr && !saw_cen, "misaligned word store not rejected cleanly");
        check("mem[0x80]", mem[32], m);
        issue(ls_instr(lh_cr, 4'd7, 4'd0, 2'd0, 12'h000), 32'h41);
        expect_true(got_aerr && !saw_cen, "odd halfword load not rejected cleanly");
        issue(sg_instr(gather_h, 4'd7, 4'd8, 4'd0), 32'h200);
        expect_true(got_aerr && !saw_cen, "odd gather offset not rejected cleanly");
        err_en   = 1'b1;
        err_addr = 32'h140;
        issue(ls_instr(ld_w, 4'd7, 4'd0, 2'd0, 12'h000), 32'h140);
        expect_true(got_berr && !got_aerr, "bus error not reported");
        err_en = 1'b0;
        read_reg(4'd7, v);
        check("cpr7", v, 32'h77771234);
        report("errors", e0);
    endtask

    initial begin
        g_resetn    = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        gpr_rs1     = '0;
        mem_rsp     = '0;
        stall_en    = 1'b0;
        err_en      = 1'b0;
        err_addr    = '0;
        stall_left  = 0;
        for (int i = 0; i < 256; i++) mem[i] = fill(i);
        repeat (16) @(negedge g_clk);
        g_resetn = 1'b1;

        test_word_round_trip("");
        test_narrow_loads("");
        test_narrow_stores("");
        test_scatter_gather("");
        test_errors();
        stall_en = 1'b1;   // Same expectations under random back-pressure
        test_word_round_trip(" (stalls)");
        test_narrow_loads(" (stalls)");
        test_narrow_stores(" (stalls)");
        test_scatter_gather(" (stalls)");

        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/cop_pkg.sv
src/cop_decode.sv
src/cop_regfile.sv
src/cop_mem.sv
src/cop_top.sv
bench/cop_sva.sv
bench/cop_tb.sv

// ==== src/cop_decode.sv ====
/*
 * Coprocessor instruction decoder
 * Splits the held instruction word into the decoded struct, picking
 * the single access or scatter/gather view by subclass
 */
module cop_decode (
    input  cop_pkg::cop_instr_u instr,
    output cop_pkg::cop_id_t    id
);
    import cop_pkg::*;

    logic is_sg;    // Word follows the scatter/gather view

    always_comb begin
        case (instr.ls.sclass)
            gather_b,
            gather_h,
            scatter_b,
            scatter_h: is_sg = 1'b1;
            default:   is_sg = 1'b0;
        endcase
    end

    always_comb begin
        id = '0;

        // Fields common to both views
        id.cls    = instr.ls.cls;
        id.sclass = instr.ls.sclass;
        id.rd     = instr.ls.rd;
        id.rs2    = instr.ls.rs2;

        if (is_sg) begin
            id.rs3 = instr.sg.rs3;
        end else begin
            id.wb_h = instr.ls.wb_h;
            id.wb_b = instr.ls.wb_b;
            id.imm  = {{20{instr.ls.imm[11]}}, instr.ls.imm};
        end
    end

endmodule

// ==== src/cop_mem.sv ====
/*
 * Coprocessor memory access block
 * Word/half/byte loads and stores plus scatter/gather sequencing,
 * lane steering to the bus and to CPR writeback, address and bus errors
 */
module cop_mem (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  valid,
    input  cop_pkg::cop_id_t      id,
    input  logic [31:0]           gpr_rs1,
    input  logic [31:0]           cpr_rs2,
    input  logic [31:0]           cpr_rs3,
    output logic                  done,
    output logic                  addr_error,
    output logic                  bus_error,
    output logic                  is_store,
    output logic [3:0]            wb_ben,
    output logic [31:0]           wb_data,
    output cop_pkg::cop_mem_req_t req,
    input  cop_pkg::cop_mem_rsp_t rsp
);
    import cop_pkg::*;

    logic        is_mem;
    logic        is_lw, is_lh, is_lb;
    logic        is_sw, is_sh, is_sb;
    logic        is_ga_b, is_ga_h, is_sc_b, is_sc_h;
    logic        any_op;
    logic        word_op, half_op, byte_op, sg_op;
    logic [1:0]  step;          // Step whose response is due
    logic [1:0]  n_step;        // Step of the request on the bus
    logic [1:0]  last_step;
    logic        p_cen;         // A request went out last cycle
    logic [1:0]  p_addr_lsbs;   // Byte offset of that request
    logic        txn_good;
    logic [15:0] sg_offset;
    logic [31:0] addr;
    logic [3:0]  lane_ben;
    logic [15:0] st_half;
    logic [1:0]  st_byte_sel;
    logic [31:0] st_byte_src;
    logic [7:0]  st_byte;
    logic [15:0] ld_half;
    logic [7:0]  ld_byte;
    logic        ld_half_hi;    // Destination half for half loads
    logic [1:0]  ld_byte_part;  // Destination byte for byte loads
    logic [3:0]  ld_ben;

    assign is_mem  = valid && id.cls == iclass_loadstore;
    assign is_lw   = is_mem && id.sclass == ld_w;
    assign is_lh   = is_mem && id.sclass == lh_cr;
    assign is_lb   = is_mem && id.sclass == lb_cr;
    assign is_sw   = is_mem && id.sclass == st_w;
    assign is_sh   = is_mem && id.sclass == st_h;
    assign is_sb   = is_mem && id.sclass == st_b;
    assign is_ga_b = is_mem && id.sclass == gather_b;
    assign is_ga_h = is_mem && id.sclass == gather_h;
    assign is_sc_b = is_mem && id.sclass == scatter_b;
    assign is_sc_h = is_mem && id.sclass == scatter_h;

    assign word_op = is_lw || is_sw;
    assign half_op = is_lh || is_sh || is_ga_h || is_sc_h;
    assign byte_op = is_lb || is_sb || is_ga_b || is_sc_b;
    assign sg_op   = is_ga_b || is_ga_h || is_sc_b || is_sc_h;
    assign any_op  = word_op || half_op || byte_op;   // Unknown subclasses are ignored

    assign is_store  = is_sw || is_sh || is_sb || is_sc_b || is_sc_h;
    assign last_step = (is_ga_b || is_sc_b) ? 2'd3 :
                       (is_ga_h || is_sc_h) ? 2'd1 : 2'd0;

    // Checked on the operands so the step logic never waits on the adder
    always_comb begin
        addr_error = 1'b0;
        if (word_op) begin
            addr_error = |(gpr_rs1[1:0] + id.imm[1:0]);
        end else if (is_lh || is_sh) begin
            addr_error = gpr_rs1[0] || id.imm[0];
        end else if (is_ga_h || is_sc_h) begin
            addr_error = gpr_rs1[0] || cpr_rs2[0] || cpr_rs2[16];
        end
    end

    // Response handling
    assign txn_good  = p_cen && !rsp.stall && !rsp.error;
    assign bus_error = p_cen && !rsp.stall && rsp.error;
    assign done      = (txn_good && step == last_step) || bus_error || addr_error;

    always_comb begin
        if (bus_error || (txn_good && step == last_step)) begin
            n_step = 2'd0;     // Finished or abandoned
        end else if (txn_good) begin
            n_step = step + 2'd1;
        end else begin
            n_step = step;     // Waiting or stalled
        end
    end

    // Offset field of rs2 for the request step
    always_comb begin
        if (byte_op) begin
            sg_offset = {8'h00, cpr_rs2[{n_step, 3'b000} +: 8]};
        end else begin
            sg_offset = n_step[0] ? cpr_rs2[31:16] : cpr_rs2[15:0];
        end
    end

    assign addr = gpr_rs1 + (sg_op ? {16'h0000, sg_offset} : id.imm);

    always_comb begin
        if (word_op) begin
            lane_ben = 4'b1111;
        end else if (half_op) begin
            lane_ben = addr[1] ? 4'b1100 : 4'b0011;
        end else begin
            lane_ben = 4'b0001 << addr[1:0];
        end
    end

    // Store data selection
    assign st_half     = is_sc_h ? (n_step[0] ? cpr_rs3[31:16] : cpr_rs3[15:0]) :
                                   (id.wb_h   ? cpr_rs2[31:16] : cpr_rs2[15:0]);
    assign st_byte_sel = is_sc_b ? n_step : {id.wb_h, id.wb_b};
    assign st_byte_src = is_sc_b ? cpr_rs3 : cpr_rs2;
    assign st_byte     = st_byte_src[{st_byte_sel, 3'b000} +: 8];

    always_comb begin
        req.cen  = any_op && !done;
        req.wen  = is_store;
        req.addr = {addr[31:2], 2'b00};
        req.ben  = is_store ? lane_ben : 4'b0000;
        if (word_op) begin
            req.wdata = cpr_rs2;
        end else if (half_op) begin
            req.wdata = {16'h0000, st_half} << {addr[1], 4'b0000};
        end else begin
            req.wdata = {24'h000000, st_byte} << {addr[1:0], 3'b000};
        end
    end

    // Load data steering, lane taken from the request being answered
    assign ld_half      = p_addr_lsbs[1] ? rsp.rdata[31:16] : rsp.rdata[15:0];
    assign ld_byte      = rsp.rdata[{p_addr_lsbs, 3'b000} +: 8];
    assign ld_half_hi   = is_ga_h ? step[0] : id.wb_h;
    assign ld_byte_part = is_ga_b ? step : {id.wb_h, id.wb_b};

    always_comb begin
        wb_data = rsp.rdata;
        ld_ben  = 4'b0000;
        if (is_lw) begin
            ld_ben = 4'b1111;
        end else if (is_lh || is_ga_h) begin
            wb_data = {2{ld_half}};
            if (ld_half_hi) begin
                ld_ben = 4'b1100;
            end else if (is_lh) begin
                wb_data = {16'h0000, ld_half};   // Clears the high half
                ld_ben  = 4'b1111;
            end else begin
                ld_ben = 4'b0011;
            end
        end else if (is_lb || is_ga_b) begin
            wb_data = {4{ld_byte}};
            if (is_lb && ld_byte_part == 2'd0) begin
                wb_data = {24'h000000, ld_byte}; // Clears bytes 3..1
                ld_ben  = 4'b1111;
            end else begin
                ld_ben = 4'b0001 << ld_byte_part;
            end
        end
    end

    assign wb_ben = txn_good ? ld_ben : 4'b0000;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            step  <= 2'd0;
            p_cen <= 1'b0;
        end else begin
            step  <= n_step;
            p_cen <= req.cen;
        end
    end

    always_ff @(posedge g_clk) begin
        p_addr_lsbs <= addr[1:0];
    end

endmodule

// ==== src/cop_pkg.sv ====
/*
 * Coprocessor load/store package
 * Instruction class and subclass codes, the two views of the
 * instruction word, the decoded instruction and the memory bus structs
 */
package cop_pkg;

    typedef enum logic [3:0] {
        iclass_loadstore = 4'd1
    } cop_iclass_e;

    typedef enum logic [4:0] {
        lb_cr     = 5'b00001,
        lh_cr     = 5'b00010,
        ld_w      = 5'b00100,
        st_b      = 5'b01001,
        st_h      = 5'b01010,
        st_w      = 5'b01100,
        gather_b  = 5'b10001,
        gather_h  = 5'b10010,
        scatter_b = 5'b11001,
        scatter_h = 5'b11010
    } cop_sclass_e;

    // Single access view
    typedef struct packed {
        cop_iclass_e cls;      // 31:28
        cop_sclass_e sclass;   // 27:23
        logic [3:0]  rd;       // 22:19
        logic [3:0]  rs2;      // 18:15
        logic        wb_h;     // 14
        logic        wb_b;     // 13
        logic        rsvd;     // 12
        logic [11:0] imm;      // Signed offset
    } cop_instr_ls_t;

    // Scatter/gather view, shares the upper fields
    typedef struct packed {
        cop_iclass_e cls;
        cop_sclass_e sclass;
        logic [3:0]  rd;
        logic [3:0]  rs2;      // Offsets per step
        logic [3:0]  rs3;      // 14:11, data per step
        logic [10:0] rsvd;
    } cop_instr_sg_t;

    typedef union packed {
        cop_instr_ls_t ls;
        cop_instr_sg_t sg;
    } cop_instr_u;

    typedef struct packed {
        cop_iclass_e cls;
        cop_sclass_e sclass;
        logic        wb_h;
        logic        wb_b;
        logic [31:0] imm;      // Already sign extended
        logic [3:0]  rd;
        logic [3:0]  rs2;
        logic [3:0]  rs3;
    } cop_id_t;

    typedef struct packed {
        logic        cen;
        logic        wen;
        logic [31:0] addr;     // Word aligned
        logic [31:0] wdata;
        logic [3:0]  ben;
    } cop_mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        stall;
        logic        error;
    } cop_mem_rsp_t;

endpackage

// ==== src/cop_regfile.sv ====
/*
 * Coprocessor register file
 * Sixteen 32-bit registers, two combinational read ports and one
 * write port with byte enables
 */
module cop_regfile (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic [3:0]  rs2_idx,
    input  logic [3:0]  rs3_idx,
    input  logic [3:0]  rd_idx,
    output logic [31:0] rs2,
    output logic [31:0] rs3,
    input  logic [3:0]  wr_ben,
    input  logic [31:0] wr_data
);

    logic [31:0] regs [16];

    assign rs2 = regs[rs2_idx];
    assign rs3 = regs[rs3_idx];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Only enabled bytes change, the rest keep their value
            for (int b = 0; b < 4; b++) begin
                if (wr_ben[b]) begin
                    regs[rd_idx][{b[1:0], 3'b000} +: 8] <= wr_data[{b[1:0], 3'b000} +: 8];
                end
            end
        end
    end

endmodule

// ==== src/cop_top.sv ====
/*
 * Coprocessor load/store subsystem
 * Decoder, CPR file and memory access block between the core and the bus
 */
module cop_top (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  instr_valid,
    input  cop_pkg::cop_instr_u   instr,
    input  logic [31:0]           gpr_rs1,
    output logic                  instr_done,
    output logic                  addr_error,
    output logic                  bus_error,
    output logic                  is_store,
    output cop_pkg::cop_mem_req_t mem_req,
    input  cop_pkg::cop_mem_rsp_t mem_rsp
);
    import cop_pkg::*;

    cop_id_t     id;
    logic [31:0] cpr_rs2;
    logic [31:0] cpr_rs3;
    logic [3:0]  wb_ben;
    logic [31:0] wb_data;

    cop_decode u_decode (
        .instr (instr),
        .id    (id)
    );

    cop_regfile u_regfile (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .rs2_idx  (id.rs2),
        .rs3_idx  (id.rs3),
        .rd_idx   (id.rd),
        .rs2      (cpr_rs2),
        .rs3      (cpr_rs3),
        .wr_ben   (wb_ben),
        .wr_data  (wb_data)
    );

    cop_mem u_mem (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .valid      (instr_valid),
        .id         (id),
        .gpr_rs1    (gpr_rs1),
        .cpr_rs2    (cpr_rs2),
        .cpr_rs3    (cpr_rs3),
        .done       (instr_done),
        .addr_error (addr_error),
        .bus_error  (bus_error),
        .is_store   (is_store),
        .wb_ben     (wb_ben),
        .wb_data    (wb_data),
        .req        (mem_req),
        .rsp        (mem_rsp)
    );

endmodule
